//--- hdl/fetch_pkg.sv
package fetch_pkg;

    localparam int unsigned INST_W = 32;  // rv32 instruction word
    localparam int unsigned ADDR_W = 32;  // byte address of an instruction
    localparam int unsigned INT_W  = 8;   // peripheral interrupt lines

    typedef logic [INST_W-1:0] inst_t;
    typedef logic [ADDR_W-1:0] inst_addr_t;
    typedef logic [INT_W-1:0]  int_flag_t;

    // pipeline hold request coming from later stages
    typedef enum logic [1:0] {
        HOLD_NONE  = 2'b00,  // run freely
        HOLD_PC    = 2'b01,  // stop fetching, let buffer drain
        HOLD_CLEAR = 2'b10   // drop buffer, redirect to jump target
    } hold_flag_e;

    typedef enum logic [1:0] {
        FS_RESET = 2'd0,  // single cycle after reset release
        FS_FETCH = 2'd1,  // requests allowed
        FS_HOLD  = 2'd2,  // stalled by hold
        FS_FLUSH = 2'd3   // cycle after a clear
    } fetch_state_e;

    localparam inst_addr_t RESET_PC_DEFAULT = 32'h0000_0000;  // boot address
    localparam inst_addr_t INST_STEP        = 32'd4;          // no compressed insts

endpackage

//--- hdl/pc_gen.sv
module pc_gen #(
    parameter fetch_pkg::inst_addr_t RESET_PC = fetch_pkg::RESET_PC_DEFAULT
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  fetch_accept_i,  // req and ready this cycle
    input  fetch_pkg::hold_flag_e hold_flag_i,     // clear loads the jump target
    input  fetch_pkg::inst_addr_t jump_addr_i,     // redirect address

    output fetch_pkg::inst_addr_t pc_o,            // address being fetched
    output fetch_pkg::inst_addr_t pc_next_o        // sequential successor
);

    import fetch_pkg::*;

    inst_addr_t pc_q;    // fetch address register
    inst_addr_t pc_seq;  // pc + 4
    logic       redirect;

    assign redirect  = hold_flag_i == HOLD_CLEAR;  // checked here on its own
    assign pc_seq    = pc_q + INST_STEP;
    assign pc_o      = pc_q;
    assign pc_next_o = pc_seq;  // travels with the inst into if_id

    // the clear has priority over an accepted fetch; the controller keeps
    // the request low under any hold, so both never coincide in practice
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;  // boot address
        end else if (redirect) begin
            pc_q <= jump_addr_i;  // jump target
        end else if (fetch_accept_i) begin
            pc_q <= pc_seq;  // advance after accepted fetch
        end
    end

endmodule

//--- hdl/fetch_ctrl.sv
module fetch_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  fetch_pkg::hold_flag_e hold_flag_i,   // from later stages
    input  logic                  buf_full_i,    // if_id has no room
    input  logic                  instr_ready_i, // memory takes the request

    output logic                  instr_req_o,    // fetch request to memory
    output logic                  fetch_accept_o, // req/ready coincidence
    output logic                  flush_o         // drop if_id contents
);

    import fetch_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;
    logic         hold_none;   // free running
    logic         hold_clear;  // flush and redirect
    logic         fetching;    // state allows requests

    assign hold_none  = hold_flag_i == HOLD_NONE;
    assign hold_clear = hold_flag_i == HOLD_CLEAR;
    assign fetching   = state_q == FS_FETCH;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            FS_RESET, FS_HOLD, FS_FLUSH: begin
                state_d = hold_none ? FS_FETCH : FS_HOLD;  // resume one cycle later
            end
            FS_FETCH: begin
                if (!hold_none) begin
                    state_d = FS_HOLD;  // HOLD_PC or unknown code
                end
            end
            default: begin
                state_d = FS_RESET;
            end
        endcase
        if (hold_clear) begin
            state_d = FS_FLUSH;  // clear wins from any state
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= FS_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // request only with room in the buffer and no hold pending
    assign instr_req_o    = fetching & hold_none & ~buf_full_i;
    assign fetch_accept_o = instr_req_o & instr_ready_i;  // zero wait memory
    assign flush_o        = hold_clear;  // buffer empties at the next edge

endmodule

//--- hdl/if_id.sv
module if_id #(
    parameter int unsigned BUF_DEPTH = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  flush_i,           // drop everything buffered
    input  logic                  push_i,            // accepted fetch
    input  fetch_pkg::inst_t      inst_i,            // fetched word
    input  fetch_pkg::inst_addr_t inst_addr_i,       // its address
    input  fetch_pkg::inst_addr_t inst_addr_next_i,  // address + 4
    input  fetch_pkg::int_flag_t  int_flag_i,        // irq flags at fetch time

    input  logic                  pop_ready_i,       // decode can take an item
    output logic                  full_o,            // no room for a push
    output logic                  valid_o,           // item on the outputs
    output fetch_pkg::inst_t      inst_o,
    output fetch_pkg::inst_addr_t inst_addr_o,
    output fetch_pkg::inst_addr_t inst_addr_next_o,
    output fetch_pkg::int_flag_t  int_flag_o
);

    import fetch_pkg::*;

    localparam int unsigned PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    inst_t      inst_mem [BUF_DEPTH];  // payload, no reset
    inst_addr_t addr_mem [BUF_DEPTH];
    inst_addr_t next_mem [BUF_DEPTH];
    int_flag_t  flag_mem [BUF_DEPTH];

    ptr_t rd_ptr_q;
    ptr_t wr_ptr_q;
    cnt_t count_q;   // entries held
    logic empty;
    logic pop;       // decode takes the head
    logic bypass;    // push goes straight to decode
    logic store;     // push lands in the array
    logic drain;     // head leaves the array

    function automatic ptr_t ptr_inc(ptr_t ptr);
        return (ptr == ptr_t'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;  // wrap at depth
    endfunction

    assign empty   = count_q == '0;
    assign full_o  = count_q == cnt_t'(BUF_DEPTH);
    assign valid_o = (~empty | push_i) & ~flush_i;  // flushed items never shown
    assign pop     = valid_o & pop_ready_i;
    assign bypass  = empty & push_i & pop;
    assign store   = push_i & ~bypass & ~flush_i & (~full_o | pop);
    assign drain   = pop & ~empty;

    // fall through when empty, else the head entry
    assign inst_o           = empty ? inst_i           : inst_mem[rd_ptr_q];
    assign inst_addr_o      = empty ? inst_addr_i      : addr_mem[rd_ptr_q];
    assign inst_addr_next_o = empty ? inst_addr_next_i : next_mem[rd_ptr_q];
    assign int_flag_o       = empty ? int_flag_i       : flag_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (store) begin
            inst_mem[wr_ptr_q] <= inst_i;
            addr_mem[wr_ptr_q] <= inst_addr_i;
            next_mem[wr_ptr_q] <= inst_addr_next_i;
            flag_mem[wr_ptr_q] <= int_flag_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;  // empty in one edge
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (store) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (drain) rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({store, drain})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // none or both
            endcase
        end
    end

endmodule

//--- hdl/fetch_top.sv
module fetch_top #(
    parameter fetch_pkg::inst_addr_t RESET_PC  = fetch_pkg::RESET_PC_DEFAULT,
    parameter int unsigned           BUF_DEPTH = 2  // if_id entries, 1 or 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // pipeline control
    input  fetch_pkg::hold_flag_e hold_flag_i,
    input  fetch_pkg::inst_addr_t jump_addr_i,   // target on clear
    input  fetch_pkg::int_flag_t  int_flag_i,    // peripheral irqs

    // instruction memory port
    output logic                  instr_req_o,
    output fetch_pkg::inst_addr_t instr_addr_o,
    input  logic                  instr_ready_i,
    input  fetch_pkg::inst_t      inst_i,        // data for instr_addr_o

    // decode port
    input  logic                  ready_from_id_i,
    output logic                  valid_to_id_o,
    output fetch_pkg::inst_t      inst_o,
    output fetch_pkg::inst_addr_t inst_addr_o,
    output fetch_pkg::inst_addr_t inst_addr_next_o,
    output fetch_pkg::int_flag_t  int_flag_o
);

    import fetch_pkg::*;

    logic       fetch_accept;  // req and ready together
    logic       flush;         // clear cycle
    logic       buf_full;      // if_id has no room
    inst_addr_t pc;            // current fetch address
    inst_addr_t pc_next;       // pc + 4

    assign instr_addr_o = pc;

    pc_gen #(
        .RESET_PC(RESET_PC)
    ) u_pc_gen (
        .clk_i,
        .rst_n_i,
        .fetch_accept_i(fetch_accept),
        .hold_flag_i,
        .jump_addr_i,
        .pc_o          (pc),
        .pc_next_o     (pc_next)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk_i,
        .rst_n_i,
        .hold_flag_i,
        .buf_full_i    (buf_full),
        .instr_ready_i,
        .instr_req_o,
        .fetch_accept_o(fetch_accept),
        .flush_o       (flush)
    );

    if_id #(
        .BUF_DEPTH(BUF_DEPTH)
    ) u_if_id (
        .clk_i,
        .rst_n_i,
        .flush_i         (flush),
        .push_i          (fetch_accept),
        .inst_i,
        .inst_addr_i     (pc),
        .inst_addr_next_i(pc_next),
        .int_flag_i,           // sampled with the accepted fetch
        .pop_ready_i     (ready_from_id_i),
        .full_o          (buf_full),
        .valid_o         (valid_to_id_o),
        .inst_o,
        .inst_addr_o,
        .inst_addr_next_o,
        .int_flag_o
    );

endmodule

//--- verification/fetch_props.sv
module fetch_props (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input fetch_pkg::hold_flag_e   hold_flag_i,
    input logic                    instr_req_o,
    input logic                    ready_from_id_i,
    input logic                    valid_to_id_o,
    input fetch_pkg::inst_t        inst_o,
    input fetch_pkg::inst_addr_t   inst_addr_o,
    input fetch_pkg::inst_addr_t   inst_addr_next_o,
    input fetch_pkg::int_flag_t    int_flag_o
);

    import fetch_pkg::*;

    // stalled item stays put unless a clear drops it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_to_id_o && !ready_from_id_i |=> (hold_flag_i == HOLD_CLEAR) ||
        (valid_to_id_o && $stable(inst_o) && $stable(inst_addr_o) &&
         $stable(inst_addr_next_o) && $stable(int_flag_o)))
        else $error("decode outputs changed while stalled");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hold_flag_i != HOLD_NONE |-> !instr_req_o)
        else $error("fetch request under a hold");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hold_flag_i == HOLD_CLEAR |=> !valid_to_id_o)  // buffer empty and no request pending
        else $error("valid seen in the cycle after a clear");

endmodule

bind fetch_top fetch_props u_fetch_props (
    .clk_i,
    .rst_n_i,
    .hold_flag_i,
    .instr_req_o,
    .ready_from_id_i,
    .valid_to_id_o,
    .inst_o,
    .inst_addr_o,
    .inst_addr_next_o,
    .int_flag_o
);

//--- verification/fetch_tb.sv
module fetch_tb;

    import fetch_pkg::*;

    localparam inst_addr_t  RESET_PC  = RESET_PC_DEFAULT;
    localparam int unsigned MEM_WORDS = 256;  // table covers the first 1 KiB
    localparam int          TIMEOUT   = 200;  // cycles allowed per wait

    logic       clk = 1'b0;
    logic       rst_n;
    hold_flag_e hold_flag;
    inst_addr_t jump_addr;
    int_flag_t  int_flag;
    logic       instr_req;
    inst_addr_t instr_addr;
    logic       instr_ready;
    inst_t      inst_mem;       // memory read data
    logic       ready_from_id;
    logic       valid_to_id;
    inst_t      inst_id;
    inst_addr_t addr_id;
    inst_addr_t next_id;
    int_flag_t  flag_id;

    inst_t      mem_tab [MEM_WORDS];   // instruction memory image
    int_flag_t  flag_log [MEM_WORDS];  // flags driven when a word was accepted
    inst_t      got_inst [$];          // decode model
    inst_addr_t got_addr [$];
    inst_addr_t got_next [$];
    int_flag_t  got_flag [$];

    string      t_name [$];     // one entry per test line
    string      t_cmd [$];
    int         t_items [$];
    int         t_mem_pct [$];
    int         t_dec_pct [$];
    inst_addr_t t_target [$];
    inst_addr_t t_start [$];

    int         mem_pct = 0;   // memory ready chance in percent
    inst_addr_t exp_addr;      // next address decode should see
    int         errors = 0;
    int         checks = 0;
    int         tests  = 0;

    fetch_top #(
        .RESET_PC (RESET_PC),
        .BUF_DEPTH(2)
    ) DUT (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .hold_flag_i     (hold_flag),
        .jump_addr_i     (jump_addr),
        .int_flag_i      (int_flag),
        .instr_req_o     (instr_req),
        .instr_addr_o    (instr_addr),
        .instr_ready_i   (instr_ready),
        .inst_i          (inst_mem),
        .ready_from_id_i (ready_from_id),
        .valid_to_id_o   (valid_to_id),
        .inst_o          (inst_id),
        .inst_addr_o     (addr_id),
        .inst_addr_next_o(next_id),
        .int_flag_o      (flag_id)
    );

    always #20 clk = ~clk;  // period 40

    // zero wait memory answering the current address
    assign inst_mem = (instr_addr < inst_addr_t'(MEM_WORDS * 4)) ? mem_tab[instr_addr[9:2]]
                                                                 : fill_word(instr_addr);

    // acceptance log and decode model sampled at the active edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (instr_req && instr_ready) begin
                flag_log[instr_addr[9:2]] = int_flag;  // flags belong to this word
            end
            if (instr_req && hold_flag != HOLD_NONE) begin
                errors = errors + 1;
                $display("fetch request raised while a hold is active at %0t", $time);
            end
            if (valid_to_id && ready_from_id) begin
                got_inst.push_back(inst_id);
                got_addr.push_back(addr_id);
                got_next.push_back(next_id);
                got_flag.push_back(flag_id);
            end
        end
    end

    function automatic inst_t fill_word(input inst_addr_t addr);
        return addr ^ 32'h5a5a_a5a5;  // words missing from the table
    endfunction

    function automatic inst_t table_word(input inst_addr_t addr);
        if (addr < inst_addr_t'(MEM_WORDS * 4)) begin
            return mem_tab[addr[9:2]];
        end
        return fill_word(addr);
    endfunction

    task automatic check_inst(input string name, input string what,
                              input inst_t exp, input inst_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input string what,
                              input inst_addr_t exp, input inst_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input int_flag_t exp, input int_flag_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // new memory ready, decode ready and irq flags for the coming edge
    task automatic drive_inputs(input int dec_pct);
        instr_ready   = int'($urandom % 100) < mem_pct;
        ready_from_id = int'($urandom % 100) < dec_pct;
        int_flag      = int_flag_t'($urandom);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        drive_inputs(0);  // decode refuses
    endtask

    // decode takes n items and compares each with the sequential rule
    task automatic consume_items(input string name, input int n, input int dec_pct);
        int taken;
        int cycles;
        taken  = 0;
        cycles = 0;
        while (taken < n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            while (got_addr.size() > 0) begin
                check_addr(name, "address", exp_addr, got_addr.pop_front());
                check_inst(name, "instruction", table_word(exp_addr), got_inst.pop_front());
                check_addr(name, "next address", exp_addr + 4, got_next.pop_front());
                check_flag(name, "irq flags", flag_log[exp_addr[9:2]], got_flag.pop_front());
                exp_addr = exp_addr + 4;
                taken++;
            end
            drive_inputs((taken < n) ? dec_pct : 0);  // never more than n
        end
        if (taken < n) begin
            abort_run({"timeout waiting for decode items in test ", name});
        end
    endtask

    // full buffer is the only reason for a low request here
    task automatic wait_buffer_full(input string name);
        int cycles;
        cycles = 0;
        while (instr_req && cycles < TIMEOUT) begin
            idle_cycle();
            cycles++;
        end
        if (instr_req) begin
            abort_run({"timeout waiting for a full buffer in test ", name});
        end
    endtask

    task automatic load_stimulus();
        int         fd;
        int         rc;
        int         idx;
        int         items;
        int         mpct;
        int         dpct;
        inst_t      word;
        inst_addr_t target;
        inst_addr_t start;
        string      line;
        string      name;
        string      cmd;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_tab[i]  = fill_word(inst_addr_t'(i * 4));
            flag_log[i] = '0;
        end
        fd = $fopen("verification/fetch_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0) begin
                    if ($sscanf(line, "mem %h %h", idx, word) == 2) begin
                        mem_tab[idx % MEM_WORDS] = word;
                    end else if ($sscanf(line, "test %s %s %d %d %d %h %h", name, cmd, items,
                                         mpct, dpct, target, start) == 7) begin
                        t_name.push_back(name);
                        t_cmd.push_back(cmd);
                        t_items.push_back(items);
                        t_mem_pct.push_back(mpct);
                        t_dec_pct.push_back(dpct);
                        t_target.push_back(target);
                        t_start.push_back(start);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int i);
        int errs_before;
        errs_before = errors;
        mem_pct     = t_mem_pct[i];
        exp_addr    = t_start[i];  // first address this test expects
        if (t_cmd[i] == "run") begin
            consume_items(t_name[i], t_items[i], t_dec_pct[i]);
        end else if (t_cmd[i] == "hold") begin
            wait_buffer_full(t_name[i]);
            hold_flag = HOLD_PC;  // no new fetches while the buffer drains
            consume_items(t_name[i], t_items[i], t_dec_pct[i]);
            repeat (4) idle_cycle();  // empty buffer and still no request
            hold_flag = HOLD_NONE;
        end else if (t_cmd[i] == "clear") begin
            hold_flag = HOLD_CLEAR;  // decode ready is low here
            jump_addr = t_target[i];
            idle_cycle();
            hold_flag = HOLD_NONE;
            consume_items(t_name[i], t_items[i], t_dec_pct[i]);
        end else begin
            errors++;
            $display("unknown command %s in test %s", t_cmd[i], t_name[i]);
        end
        tests++;
        $display("test %s done with %0d errors", t_name[i], errors - errs_before);
    endtask

    initial begin
        int seed;
        rst_n         = 1'b0;
        hold_flag     = HOLD_NONE;
        jump_addr     = '0;
        int_flag      = '0;
        instr_ready   = 1'b0;
        ready_from_id = 1'b0;
        exp_addr      = RESET_PC;
        seed          = $urandom(32'h1e1c229a);  // one seed for the whole run
        load_stimulus();

        repeat (4) begin
            @(posedge clk);
            if (instr_req || valid_to_id) begin
                errors++;
                $display("request or valid high during reset");
            end
        end
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);  // edge that leaves FS_RESET
        if (instr_req || valid_to_id) begin
            errors++;
            $display("request or valid high in the first cycle after reset");
        end
        check_addr("reset", "fetch address", RESET_PC, instr_addr);
        idle_cycle();
        tests++;
        $display("test reset done with %0d errors", errors);

        foreach (t_name[i]) begin
            run_test(i);
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verification/fetch_stimulus.txt
# mem <word index> <instruction word>, words left out get a fill pattern
# test <name> <cmd> <items> <mem ready %> <decode ready %> <jump target> <first addr>
mem 00 00000093
mem 01 00100113
mem 02 00208193
mem 03 00310233
mem 04 004182b3
mem 05 00520333
mem 06 006283b3
mem 07 00730433
mem 08 008384b3
mem 09 00940533
mem 0a 00a485b3
mem 0b fe000ae3
mem 20 0aa00513
mem 21 00b50533
mem 22 00a02023
mem 23 00002583
mem 24 0000006f
test boot     run    6 100 100 00000000 00000000
test random   run   10  60  50 00000000 00000018
test hold     hold   2  70  50 00000000 00000040
test resume   run    4  80  70 00000000 00000048
test clear    clear  5  70  60 00000080 00000080
test stall    run    8  50  20 00000000 00000094
test clear_bk clear  3 100 100 00000010 00000010
test tail     run    4  90  90 00000000 0000001c

//--- fetch_front.f
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/fetch_ctrl.sv
hdl/if_id.sv
hdl/fetch_top.sv
verification/fetch_props.sv
verification/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_front

sources:
  - hdl/fetch_pkg.sv
  - hdl/pc_gen.sv
  - hdl/fetch_ctrl.sv
  - hdl/if_id.sv
  - hdl/fetch_top.sv
  - target: test
    files:
      - verification/fetch_props.sv
      - verification/fetch_tb.sv
